// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// ==============================
	// widths
	// ==============================
	localparam int DataWidth    = 32;
	localparam int RegAddrWidth = 5;

	// ==============================
	// opcodes, funct and rt codes
	// ==============================
	localparam logic [5:0] OpSpecial = 6'b000000;
	localparam logic [5:0] OpRegimm  = 6'b000001;
	localparam logic [5:0] OpBeq     = 6'b000100;
	localparam logic [5:0] OpBne     = 6'b000101;
	localparam logic [5:0] OpBlez    = 6'b000110;
	localparam logic [5:0] OpBgtz    = 6'b000111;
	localparam logic [5:0] OpAddi    = 6'b001000;
	localparam logic [5:0] OpAddiu   = 6'b001001;
	localparam logic [5:0] OpSlti    = 6'b001010;
	localparam logic [5:0] OpSltiu   = 6'b001011;
	localparam logic [5:0] OpAndi    = 6'b001100;
	localparam logic [5:0] OpOri     = 6'b001101;
	localparam logic [5:0] OpXori    = 6'b001110;
	localparam logic [5:0] OpLui     = 6'b001111;
	localparam logic [5:0] OpLb      = 6'b100000;
	localparam logic [5:0] OpLh      = 6'b100001;
	localparam logic [5:0] OpLw      = 6'b100011;
	localparam logic [5:0] OpLbu     = 6'b100100;
	localparam logic [5:0] OpLhu     = 6'b100101;
	localparam logic [5:0] OpSb      = 6'b101000;
	localparam logic [5:0] OpSh      = 6'b101001;
	localparam logic [5:0] OpSw      = 6'b101011;

	// special funct field
	localparam logic [5:0] FnSll  = 6'b000000;
	localparam logic [5:0] FnSrl  = 6'b000010;
	localparam logic [5:0] FnSra  = 6'b000011;
	localparam logic [5:0] FnAdd  = 6'b100000;
	localparam logic [5:0] FnAddu = 6'b100001;
	localparam logic [5:0] FnSub  = 6'b100010;
	localparam logic [5:0] FnSubu = 6'b100011;
	localparam logic [5:0] FnAnd  = 6'b100100;
	localparam logic [5:0] FnOr   = 6'b100101;
	localparam logic [5:0] FnXor  = 6'b100110;
	localparam logic [5:0] FnNor  = 6'b100111;
	localparam logic [5:0] FnSlt  = 6'b101010;
	localparam logic [5:0] FnSltu = 6'b101011;

	// regimm rt field
	localparam logic [4:0] RtBltz = 5'b00000;
	localparam logic [4:0] RtBgez = 5'b00001;

	// add/sub with Ov suffix are the trapping forms
	typedef enum logic [3:0] {
		AluAdd, AluAddOv, AluSub, AluSubOv, AluAnd, AluOr, AluXor,
		AluNor, AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
	} aluOp;

	typedef enum logic [1:0] {MemByte, MemHalf, MemWord} memSize;

	typedef enum logic [2:0] {BrNone, BrEq, BrNe, BrGtz, BrLez, BrGez, BrLtz} branchCond;

	// one word, two field layouts
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFormat;

	typedef union packed {
		rFormat rType;
		iFormat iType;
	} instrWord;

endpackage

`default_nettype wire

// File: decode/regFile.sv
`default_nettype none

module regFile (
	input  wire clk,
	input  wire rst,
	input  wire [mipsPkg::RegAddrWidth-1:0] rdAddrA,
	input  wire [mipsPkg::RegAddrWidth-1:0] rdAddrB,
	output logic [mipsPkg::DataWidth-1:0] rdDataA,
	output logic [mipsPkg::DataWidth-1:0] rdDataB,
	input  wire wrEnable,
	input  wire [mipsPkg::RegAddrWidth-1:0] wrAddr,
	input  wire [mipsPkg::DataWidth-1:0] wrData
);
	import mipsPkg::*;

	// register 0 has no storage
	logic [DataWidth-1:0] regs [1:(1 << RegAddrWidth) - 1];

	// same-cycle write wins over stored value
	function automatic logic [DataWidth-1:0] readPort(input logic [RegAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wrEnable && wrAddr == addr)
			return wrData;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < (1 << RegAddrWidth); i++)
				regs[i] <= '0;
		end else if (wrEnable && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

`default_nettype wire

// File: decode/instrDecode.sv
`default_nettype none

module instrDecode (
	input  wire clk,
	input  wire rst,
	input  wire instrValid,
	input  wire mipsPkg::instrWord instr,
	input  wire [mipsPkg::DataWidth-1:0] pc,
	// register file read side
	output logic [mipsPkg::RegAddrWidth-1:0] rdAddrA,
	output logic [mipsPkg::RegAddrWidth-1:0] rdAddrB,
	input  wire [mipsPkg::DataWidth-1:0] rdDataA,
	input  wire [mipsPkg::DataWidth-1:0] rdDataB,
	// decode -> execute register
	output logic exValid,
	output logic [mipsPkg::DataWidth-1:0] exSrcA,
	output logic [mipsPkg::DataWidth-1:0] exSrcB,
	output logic [mipsPkg::RegAddrWidth-1:0] exRsAddr,
	output logic [mipsPkg::RegAddrWidth-1:0] exRtAddr,
	output logic [mipsPkg::DataWidth-1:0] exImm,
	output logic [4:0] exShamt,
	output mipsPkg::aluOp exAluOp,
	output logic exUseImm,
	output logic exShiftImm,
	output logic [mipsPkg::RegAddrWidth-1:0] exDest,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output mipsPkg::memSize exMemSize,
	output logic exLoadSigned,
	output mipsPkg::branchCond exBranchCond,
	output logic [mipsPkg::DataWidth-1:0] exPc
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [RegAddrWidth-1:0] rt;
	logic [15:0] imm;
	logic isRType, isAluImm, isLoad, isStore, isShift, zeroExt;
	aluOp aluOpD;
	memSize memSizeD;
	branchCond branchD;

	// opcode and operands from the I view, funct from the R view
	assign opcode  = instr.iType.opcode;
	assign rt      = instr.iType.rt;
	assign imm     = instr.iType.imm;
	assign funct   = instr.rType.funct;
	assign rdAddrA = instr.iType.rs;
	assign rdAddrB = rt;

	// instruction classes
	assign isRType = (opcode == OpSpecial) && (funct inside {FnAdd, FnAddu, FnSub, FnSubu,
		FnAnd, FnOr, FnXor, FnNor, FnSlt, FnSltu, FnSll, FnSrl, FnSra});
	assign isAluImm = opcode inside {OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};
	assign isLoad   = opcode inside {OpLw, OpLh, OpLhu, OpLb, OpLbu};
	assign isStore  = opcode inside {OpSw, OpSh, OpSb};
	assign isShift  = isRType && (funct inside {FnSll, FnSrl, FnSra});
	// logical immediates are zero extended
	assign zeroExt  = opcode inside {OpAndi, OpOri, OpXori};

	// ==============================
	// ALU operation
	// ==============================
	always_comb begin
		aluOpD = AluAdd;
		case (opcode)
			OpSpecial: begin
				case (funct)
					FnAdd:   aluOpD = AluAddOv;
					FnAddu:  aluOpD = AluAdd;
					FnSub:   aluOpD = AluSubOv;
					FnSubu:  aluOpD = AluSub;
					FnAnd:   aluOpD = AluAnd;
					FnOr:    aluOpD = AluOr;
					FnXor:   aluOpD = AluXor;
					FnNor:   aluOpD = AluNor;
					FnSlt:   aluOpD = AluSlt;
					FnSltu:  aluOpD = AluSltu;
					FnSll:   aluOpD = AluSll;
					FnSrl:   aluOpD = AluSrl;
					FnSra:   aluOpD = AluSra;
					default: aluOpD = AluAdd;
				endcase
			end
			OpAddi:  aluOpD = AluAddOv;
			OpSlti:  aluOpD = AluSlt;
			OpSltiu: aluOpD = AluSltu;
			OpAndi:  aluOpD = AluAnd;
			OpOri:   aluOpD = AluOr;
			OpXori:  aluOpD = AluXor;
			OpLui:   aluOpD = AluLui;
			// addiu, loads and stores add
			default: aluOpD = AluAdd;
		endcase
	end

	// access width
	always_comb begin
		case (opcode)
			OpLw, OpSw:        memSizeD = MemWord;
			OpLh, OpLhu, OpSh: memSizeD = MemHalf;
			default:           memSizeD = MemByte;
		endcase
	end

	// branch test, regimm picks by rt
	always_comb begin
		branchD = BrNone;
		case (opcode)
			OpBeq:  branchD = BrEq;
			OpBne:  branchD = BrNe;
			OpBgtz: branchD = BrGtz;
			OpBlez: branchD = BrLez;
			OpRegimm: begin
				if (rt == RtBgez)
					branchD = BrGez;
				else if (rt == RtBltz)
					branchD = BrLtz;
			end
			default: branchD = BrNone;
		endcase
	end

	// ==============================
	// decode -> execute register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			exValid      <= 1'b0;
			exRegWrite   <= 1'b0;
			exMemRead    <= 1'b0;
			exMemWrite   <= 1'b0;
			exBranchCond <= BrNone;
		end else begin
			exValid      <= instrValid;
			// unsupported words land here with every strobe low
			exRegWrite   <= instrValid && (isRType || isAluImm || isLoad);
			exMemRead    <= instrValid && isLoad;
			exMemWrite   <= instrValid && isStore;
			exBranchCond <= instrValid ? branchD : BrNone;
		end
	end

	// operands and qualifiers
	always_ff @(posedge clk) begin
		exSrcA       <= rdDataA;
		exSrcB       <= rdDataB;
		exRsAddr     <= instr.iType.rs;
		exRtAddr     <= rt;
		exImm        <= zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
		exShamt      <= instr.rType.shamt;
		exAluOp      <= aluOpD;
		exUseImm     <= isAluImm || isLoad || isStore;
		exShiftImm   <= isShift;
		// rd for R-type, rt otherwise
		exDest       <= (opcode == OpSpecial) ? instr.rType.rd : rt;
		exMemSize    <= memSizeD;
		exLoadSigned <= opcode inside {OpLh, OpLb};
		exPc         <= pc;
	end

endmodule

`default_nettype wire

// File: execute/aluExecute.sv
`default_nettype none

module aluExecute (
	input  wire clk,
	input  wire rst,
	// from decode
	input  wire exValid,
	input  wire [mipsPkg::DataWidth-1:0] exSrcA,
	input  wire [mipsPkg::DataWidth-1:0] exSrcB,
	input  wire [mipsPkg::RegAddrWidth-1:0] exRsAddr,
	input  wire [mipsPkg::RegAddrWidth-1:0] exRtAddr,
	input  wire [mipsPkg::DataWidth-1:0] exImm,
	input  wire [4:0] exShamt,
	input  wire mipsPkg::aluOp exAluOp,
	input  wire exUseImm,
	input  wire exShiftImm,
	input  wire [mipsPkg::RegAddrWidth-1:0] exDest,
	input  wire exRegWrite,
	input  wire exMemRead,
	input  wire exMemWrite,
	input  wire mipsPkg::memSize exMemSize,
	input  wire exLoadSigned,
	input  wire mipsPkg::branchCond exBranchCond,
	input  wire [mipsPkg::DataWidth-1:0] exPc,
	// result stage writeback, for forwarding
	input  wire wbEnable,
	input  wire [mipsPkg::RegAddrWidth-1:0] wbReg,
	input  wire [mipsPkg::DataWidth-1:0] wbData,
	// branch report and overflow
	output logic branchValid,
	output logic branchTaken,
	output logic [mipsPkg::DataWidth-1:0] branchTarget,
	output logic overflow,
	// execute -> result register
	output logic memValid,
	output logic [mipsPkg::DataWidth-1:0] memAddr,
	output logic [mipsPkg::DataWidth-1:0] memStoreData,
	output logic [3:0] memByteEnable,
	output logic memRead,
	output logic memWrite,
	output mipsPkg::memSize memSize,
	output logic memLoadSigned,
	output logic [mipsPkg::RegAddrWidth-1:0] memDest,
	output logic memRegWrite
);
	import mipsPkg::*;

	logic [DataWidth-1:0] opA, fwdB, opB, sum, diff, aluResult, storeData;
	logic [4:0] shiftAmt;
	logic addOv, subOv, trapOv, condTrue;
	logic [3:0] storeLanes;

	// W-to-E forwarding, wbEnable already excludes r0
	assign opA  = (wbEnable && wbReg == exRsAddr) ? wbData : exSrcA;
	assign fwdB = (wbEnable && wbReg == exRtAddr) ? wbData : exSrcB;
	assign opB  = exUseImm ? exImm : fwdB;
	assign shiftAmt = exShiftImm ? exShamt : opA[4:0];

	// ==============================
	// ALU and overflow
	// ==============================
	assign sum  = opA + opB;
	assign diff = opA - opB;
	// signed overflow from operand and result signs
	assign addOv  = (opA[DataWidth-1] == opB[DataWidth-1]) && (sum[DataWidth-1] != opA[DataWidth-1]);
	assign subOv  = (opA[DataWidth-1] != opB[DataWidth-1]) && (diff[DataWidth-1] != opA[DataWidth-1]);
	assign trapOv = ((exAluOp == AluAddOv) && addOv) || ((exAluOp == AluSubOv) && subOv);

	always_comb begin
		case (exAluOp)
			AluAdd, AluAddOv: aluResult = sum;
			AluSub, AluSubOv: aluResult = diff;
			AluAnd:  aluResult = opA & opB;
			AluOr:   aluResult = opA | opB;
			AluXor:  aluResult = opA ^ opB;
			AluNor:  aluResult = ~(opA | opB);
			AluSlt:  aluResult = {{(DataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			AluSltu: aluResult = {{(DataWidth-1){1'b0}}, opA < opB};
			// shifts act on rt
			AluSll:  aluResult = opB << shiftAmt;
			AluSrl:  aluResult = opB >> shiftAmt;
			AluSra:  aluResult = $signed(opB) >>> shiftAmt;
			AluLui:  aluResult = {opB[15:0], 16'b0};
			default: aluResult = sum;
		endcase
	end

	// ==============================
	// branch evaluation
	// ==============================
	always_comb begin
		case (exBranchCond)
			BrEq:    condTrue = (opA == fwdB);
			BrNe:    condTrue = (opA != fwdB);
			BrGtz:   condTrue = !opA[DataWidth-1] && (opA != '0);
			BrLez:   condTrue = opA[DataWidth-1] || (opA == '0);
			BrGez:   condTrue = !opA[DataWidth-1];
			BrLtz:   condTrue = opA[DataWidth-1];
			default: condTrue = 1'b0;
		endcase
	end

	// reported only, fetch is outside
	assign branchValid  = exValid && (exBranchCond != BrNone);
	assign branchTaken  = branchValid && condTrue;
	assign branchTarget = exPc + 32'd4 + {exImm[DataWidth-3:0], 2'b00};
	assign overflow     = exValid && trapOv;

	// store lanes, little endian
	always_comb begin
		case (exMemSize)
			MemByte: begin
				storeData  = {4{fwdB[7:0]}};
				storeLanes = 4'b0001 << aluResult[1:0];
			end
			MemHalf: begin
				storeData  = {2{fwdB[15:0]}};
				storeLanes = aluResult[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				storeData  = fwdB;
				storeLanes = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			memValid    <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			memRegWrite <= 1'b0;
		end else begin
			memValid    <= exValid;
			memRead     <= exValid && exMemRead;
			memWrite    <= exValid && exMemWrite;
			// trapped add/sub drops its write
			memRegWrite <= exValid && exRegWrite && !trapOv;
		end
	end

	always_ff @(posedge clk) begin
		memAddr       <= aluResult;
		memStoreData  <= storeData;
		memByteEnable <= storeLanes;
		memSize       <= exMemSize;
		memLoadSigned <= exLoadSigned;
		memDest       <= exDest;
	end

endmodule

`default_nettype wire

// File: hdl/loadResult.sv
`default_nettype none

module loadResult (
	// execute -> result register contents
	input  wire memValid,
	input  wire [mipsPkg::DataWidth-1:0] memAddr,
	input  wire [mipsPkg::DataWidth-1:0] memStoreData,
	input  wire [3:0] memByteEnable,
	input  wire memLoad,
	input  wire memStore,
	input  wire mipsPkg::memSize memSize,
	input  wire memLoadSigned,
	input  wire [mipsPkg::RegAddrWidth-1:0] memDest,
	input  wire memRegWrite,
	input  wire [mipsPkg::DataWidth-1:0] readData,
	// data memory side
	output logic [mipsPkg::DataWidth-1:0] dataAddr,
	output logic [mipsPkg::DataWidth-1:0] writeData,
	output logic [3:0] byteEnable,
	output logic memRead,
	output logic memWrite,
	// writeback
	output logic wbEnable,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [mipsPkg::DataWidth-1:0] wbData
);
	import mipsPkg::*;

	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	logic [DataWidth-1:0] loadValue;

	// ==============================
	// memory access
	// ==============================
	assign dataAddr   = memAddr;
	assign writeData  = memStoreData;
	assign memRead    = memValid && memLoad;
	assign memWrite   = memValid && memStore;
	// lanes only shown during an access
	assign byteEnable = (memRead || memWrite) ? memByteEnable : 4'b0000;

	// lane pick from low address bits
	assign loadByte = readData[8 * memAddr[1:0] +: 8];
	assign loadHalf = memAddr[1] ? readData[31:16] : readData[15:0];

	always_comb begin
		case (memSize)
			MemByte: loadValue = {{24{memLoadSigned && loadByte[7]}}, loadByte};
			MemHalf: loadValue = {{16{memLoadSigned && loadHalf[15]}}, loadHalf};
			default: loadValue = readData;
		endcase
	end

	// ==============================
	// writeback
	// ==============================
	assign wbReg    = memDest;
	assign wbData   = memLoad ? loadValue : memAddr;
	// r0 is never written
	assign wbEnable = memValid && memRegWrite && (memDest != '0);

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`default_nettype none

module mipsCore (
	input  wire clk,
	input  wire rst,
	input  wire instrValid,
	input  wire mipsPkg::instrWord instr,
	input  wire [mipsPkg::DataWidth-1:0] pc,
	input  wire [mipsPkg::DataWidth-1:0] readData,
	output logic [mipsPkg::DataWidth-1:0] dataAddr,
	output logic [mipsPkg::DataWidth-1:0] writeData,
	output logic [3:0] byteEnable,
	output logic memRead,
	output logic memWrite,
	output logic branchValid,
	output logic branchTaken,
	output logic [mipsPkg::DataWidth-1:0] branchTarget,
	output logic overflow,
	output logic wbEnable,
	output logic [mipsPkg::RegAddrWidth-1:0] wbReg,
	output logic [mipsPkg::DataWidth-1:0] wbData
);
	import mipsPkg::*;

	// register file read side
	logic [RegAddrWidth-1:0] rdAddrA, rdAddrB;
	logic [DataWidth-1:0] rdDataA, rdDataB;

	// ==============================
	// decode -> execute
	// ==============================
	logic exValid, exUseImm, exShiftImm, exRegWrite, exMemRead, exMemWrite, exLoadSigned;
	logic [DataWidth-1:0] exSrcA, exSrcB, exImm, exPc;
	logic [RegAddrWidth-1:0] exRsAddr, exRtAddr, exDest;
	logic [4:0] exShamt;
	aluOp exAluOp;
	memSize exMemSize;
	branchCond exBranchCond;

	// ==============================
	// execute -> result
	// ==============================
	logic memValid, memLoad, memStore, memLoadSigned, memRegWrite;
	logic [DataWidth-1:0] memAddr, memStoreData;
	logic [3:0] memByteEnable;
	logic [RegAddrWidth-1:0] memDest;
	memSize memLaneSize;

	// write port fed from the result stage
	regFile regFile_i (
		.*,
		.wrEnable(wbEnable),
		.wrAddr(wbReg),
		.wrData(wbData)
	);

	instrDecode instrDecode_i (.*);

	// stage register strobes renamed on the way to the result stage
	aluExecute aluExecute_i (
		.*,
		.memRead(memLoad),
		.memWrite(memStore),
		.memSize(memLaneSize)
	);

	loadResult loadResult_i (
		.*,
		.memSize(memLaneSize)
	);

endmodule

`default_nettype wire

// File: verif/mipsVectors.svh
`ifndef MIPS_VECTORS_SVH
`define MIPS_VECTORS_SVH

// columns: kind, instr, pc, readData, expA, expB, bits
// expA is dataAddr or branchTarget, expB is wbData or writeData
// bits is byteEnable for stores, taken in bit 0 for branches
task automatic loadVectors();
	// ==============================
	// arithmetic chain, registers start at zero
	// ==============================
	addVector(KAlu, 32'h24010005, 32'h100, 0, 0, 32'h00000005, 0);
	// back to back on r1, forwarded
	addVector(KAlu, 32'h342200F0, 32'h104, 0, 0, 32'h000000F5, 0);
	addVector(KAlu, 32'h3C038000, 32'h108, 0, 0, 32'h80000000, 0);
	// r2 two back, write-through read
	addVector(KAlu, 32'h00222021, 32'h10C, 0, 0, 32'h000000FA, 0);
	addVector(KAlu, 32'h00812823, 32'h110, 0, 0, 32'h000000F5, 0);
	addVector(KAlu, 32'h00A33026, 32'h114, 0, 0, 32'h800000F5, 0);
	addVector(KAlu, 32'h00C43824, 32'h118, 0, 0, 32'h000000F0, 0);
	addVector(KAlu, 32'h00E34025, 32'h11C, 0, 0, 32'h800000F0, 0);
	addVector(KAlu, 32'h01004827, 32'h120, 0, 0, 32'h7FFFFF0F, 0);
	// sll, sra, srl
	addVector(KAlu, 32'h00015100, 32'h124, 0, 0, 32'h00000050, 0);
	addVector(KAlu, 32'h00035A03, 32'h128, 0, 0, 32'hFF800000, 0);
	addVector(KAlu, 32'h000B6102, 32'h12C, 0, 0, 32'h0FF80000, 0);
	// signed vs unsigned compares
	addVector(KAlu, 32'h0061682A, 32'h130, 0, 0, 32'h00000001, 0);
	addVector(KAlu, 32'h0061702B, 32'h134, 0, 0, 32'h00000000, 0);
	addVector(KAlu, 32'h286FFFFF, 32'h138, 0, 0, 32'h00000001, 0);
	addVector(KAlu, 32'h2C30FFFF, 32'h13C, 0, 0, 32'h00000001, 0);
	// logical immediates zero extend
	addVector(KAlu, 32'h3131FFFF, 32'h140, 0, 0, 32'h0000FF0F, 0);
	addVector(KAlu, 32'h38728001, 32'h144, 0, 0, 32'h80008001, 0);
	// addi into r0
	addVector(KNoWb, 32'h20200007, 32'h148, 0, 0, 0, 0);
	// ==============================
	// overflow pairs, trapping then wrapping
	// ==============================
	addVector(KAlu, 32'h3C137FFF, 32'h14C, 0, 0, 32'h7FFF0000, 0);
	addVector(KOv, 32'h0273A020, 32'h150, 0, 0, 0, 0);
	addVector(KAlu, 32'h0273A021, 32'h154, 0, 0, 32'hFFFE0000, 0);
	addVector(KOv, 32'h0073A822, 32'h158, 0, 0, 0, 0);
	addVector(KAlu, 32'h0073A823, 32'h15C, 0, 0, 32'h00010000, 0);
	addVector(KOv, 32'h2076FFFF, 32'h160, 0, 0, 0, 0);
	addVector(KAlu, 32'h2476FFFF, 32'h164, 0, 0, 32'h7FFFFFFF, 0);
	// ==============================
	// loads off r10 = 0x50
	// ==============================
	addVector(KLd, 32'h8D570000, 32'h168, 32'hF1E27384, 32'h50, 32'hF1E27384, 0);
	addVector(KLd, 32'h85580000, 32'h16C, 32'hF1E27384, 32'h50, 32'h00007384, 0);
	addVector(KLd, 32'h85580002, 32'h170, 32'hF1E27384, 32'h52, 32'hFFFFF1E2, 0);
	addVector(KLd, 32'h95590000, 32'h174, 32'hF1E27384, 32'h50, 32'h00007384, 0);
	addVector(KLd, 32'h95590002, 32'h178, 32'hF1E27384, 32'h52, 32'h0000F1E2, 0);
	addVector(KLd, 32'h815A0000, 32'h17C, 32'hF1E27384, 32'h50, 32'hFFFFFF84, 0);
	addVector(KLd, 32'h815A0001, 32'h180, 32'hF1E27384, 32'h51, 32'h00000073, 0);
	addVector(KLd, 32'h815A0002, 32'h184, 32'hF1E27384, 32'h52, 32'hFFFFFFE2, 0);
	addVector(KLd, 32'h815A0003, 32'h188, 32'hF1E27384, 32'h53, 32'hFFFFFFF1, 0);
	addVector(KLd, 32'h915B0000, 32'h18C, 32'hF1E27384, 32'h50, 32'h00000084, 0);
	addVector(KLd, 32'h915B0001, 32'h190, 32'hF1E27384, 32'h51, 32'h00000073, 0);
	addVector(KLd, 32'h915B0002, 32'h194, 32'hF1E27384, 32'h52, 32'h000000E2, 0);
	addVector(KLd, 32'h915B0003, 32'h198, 32'hF1E27384, 32'h53, 32'h000000F1, 0);
	// loaded byte forwarded straight into addu
	addVector(KAlu, 32'h0360E021, 32'h19C, 0, 0, 32'h000000F1, 0);
	// ==============================
	// stores of r18 = 0x80008001
	// ==============================
	addVector(KSt, 32'hAD520004, 32'h1A0, 0, 32'h54, 32'h80008001, 4'hF);
	addVector(KSt, 32'hA5520000, 32'h1A4, 0, 32'h50, 32'h80018001, 4'h3);
	addVector(KSt, 32'hA5520002, 32'h1A8, 0, 32'h52, 32'h80018001, 4'hC);
	addVector(KSt, 32'hA1520000, 32'h1AC, 0, 32'h50, 32'h01010101, 4'h1);
	addVector(KSt, 32'hA1520001, 32'h1B0, 0, 32'h51, 32'h01010101, 4'h2);
	addVector(KSt, 32'hA1520002, 32'h1B4, 0, 32'h52, 32'h01010101, 4'h4);
	addVector(KSt, 32'hA1520003, 32'h1B8, 0, 32'h53, 32'h01010101, 4'h8);
	// ==============================
	// branches, taken then not taken
	// ==============================
	addVector(KBr, 32'h10210010, 32'h1BC, 0, 32'h200, 0, 1);
	addVector(KBr, 32'h10230010, 32'h1C0, 0, 32'h204, 0, 0);
	// backward offset
	addVector(KBr, 32'h1423FFF8, 32'h1C4, 0, 32'h1A8, 0, 1);
	addVector(KBr, 32'h14210010, 32'h1C8, 0, 32'h20C, 0, 0);
	addVector(KBr, 32'h1C200010, 32'h1CC, 0, 32'h210, 0, 1);
	addVector(KBr, 32'h1C600010, 32'h1D0, 0, 32'h214, 0, 0);
	addVector(KBr, 32'h18000010, 32'h1D4, 0, 32'h218, 0, 1);
	addVector(KBr, 32'h18200010, 32'h1D8, 0, 32'h21C, 0, 0);
	addVector(KBr, 32'h04010010, 32'h1DC, 0, 32'h220, 0, 1);
	addVector(KBr, 32'h04610010, 32'h1E0, 0, 32'h224, 0, 0);
	addVector(KBr, 32'h04600010, 32'h1E4, 0, 32'h228, 0, 1);
	addVector(KBr, 32'h04200010, 32'h1E8, 0, 32'h22C, 0, 0);
endtask

`endif

// File: verif/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	import mipsPkg::*;

	localparam int ResetCycles = 10;
	localparam int IdleTimeout = 20;
	// beq r0 r0 held valid in decode while reset is high
	localparam logic [31:0] ResetInstr = 32'h10000010;

	// what each row exercises
	typedef enum logic [2:0] {KAlu, KNoWb, KOv, KLd, KSt, KBr} vecKind;

	typedef struct packed {
		vecKind kind;
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] rdata;
		logic [31:0] expA;
		logic [31:0] expB;
		logic [3:0] bits;
	} vecEntry;

	logic clk, rst, instrValid;
	instrWord instr;
	logic [31:0] pc, readData, dataAddr, writeData, branchTarget, wbData;
	logic [3:0] byteEnable;
	logic memRead, memWrite, branchValid, branchTaken, overflow, wbEnable;
	logic [4:0] wbReg;

	vecEntry vecs[$];
	int errs[$];
	int passCount, failCount, resetErrs, numVecs;
	logic drained;

	mipsCore mipsCore_i (.*);

	always #4 clk = ~clk;

	task automatic addVector(input vecKind kind, input logic [31:0] word,
			input logic [31:0] addr, input logic [31:0] rdata, input logic [31:0] expA,
			input logic [31:0] expB, input logic [3:0] bits);
		vecEntry v;
		v.kind = kind;
		v.instr = word;
		v.pc = addr;
		v.rdata = rdata;
		v.expA = expA;
		v.expB = expB;
		v.bits = bits;
		vecs.push_back(v);
		errs.push_back(0);
	endtask

	`include "mipsVectors.svh"

	// k below zero is the reset test
	task automatic reportMismatch(input int k, input string name,
			input logic [31:0] expected, input logic [31:0] actual);
		if (k < 0) begin
			$display("FAIL reset %s expected %h got %h", name, expected, actual);
			resetErrs++;
		end else begin
			$display("FAIL vector %0d %s expected %h got %h", k, name, expected, actual);
			errs[k] = errs[k] + 1;
		end
	endtask

	// R-type writes rd, everything else rt
	function automatic logic [4:0] destOf(input logic [31:0] word);
		return (word[31:26] == 6'b0) ? word[15:11] : word[20:16];
	endfunction

	// ==============================
	// idle checks
	// ==============================
	task automatic quietExecute();
		if (branchValid !== 1'b0) reportMismatch(-1, "branchValid", 0, branchValid);
		if (overflow !== 1'b0) reportMismatch(-1, "overflow", 0, overflow);
	endtask

	task automatic quietResult();
		if (wbEnable !== 1'b0) reportMismatch(-1, "wbEnable", 0, wbEnable);
		if (memRead !== 1'b0) reportMismatch(-1, "memRead", 0, memRead);
		if (memWrite !== 1'b0) reportMismatch(-1, "memWrite", 0, memWrite);
	endtask

	// one cycle after issue
	task automatic checkExecute(input int k);
		vecEntry v;
		v = vecs[k];
		if (overflow !== (v.kind == KOv))
			reportMismatch(k, "overflow", v.kind == KOv, overflow);
		if (branchValid !== (v.kind == KBr))
			reportMismatch(k, "branchValid", v.kind == KBr, branchValid);
		if (v.kind == KBr) begin
			if (branchTaken !== v.bits[0])
				reportMismatch(k, "branchTaken", v.bits[0], branchTaken);
			if (branchTarget !== v.expA)
				reportMismatch(k, "branchTarget", v.expA, branchTarget);
		end
	endtask

	// result stage two cycles after issue, closes the row's test line
	task automatic checkResult(input int k);
		vecEntry v;
		logic wantWb;
		v = vecs[k];
		wantWb = (v.kind == KAlu) || (v.kind == KLd);
		if (wbEnable !== wantWb) reportMismatch(k, "wbEnable", wantWb, wbEnable);
		if (memRead !== (v.kind == KLd)) reportMismatch(k, "memRead", v.kind == KLd, memRead);
		if (memWrite !== (v.kind == KSt)) reportMismatch(k, "memWrite", v.kind == KSt, memWrite);
		if (wantWb && wbReg !== destOf(v.instr))
			reportMismatch(k, "wbReg", destOf(v.instr), wbReg);
		if (wantWb && wbData !== v.expB) reportMismatch(k, "wbData", v.expB, wbData);
		if ((v.kind == KLd || v.kind == KSt) && dataAddr !== v.expA)
			reportMismatch(k, "dataAddr", v.expA, dataAddr);
		if (v.kind == KSt && byteEnable !== v.bits)
			reportMismatch(k, "byteEnable", v.bits, byteEnable);
		if (v.kind == KSt && writeData !== v.expB)
			reportMismatch(k, "writeData", v.expB, writeData);
		if (errs[k] == 0) begin
			$display("vector %0d instr %h ok", k, v.instr);
			passCount++;
		end else begin
			$display("vector %0d instr %h had %0d mismatches", k, v.instr, errs[k]);
			failCount++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		// valid taken branch while in reset, must stay invisible
		instrValid = 1'b1;
		instr = ResetInstr;
		pc = '0;
		readData = '0;
		passCount = 0;
		failCount = 0;
		resetErrs = 0;
		loadVectors();
		numVecs = vecs.size();

		// ==============================
		// reset released after the 10th rising edge
		// ==============================
		for (int c = 0; c < ResetCycles; c++) begin
			@(negedge clk);
			if (c == ResetCycles - 1) begin
				rst = 1'b0;
				instrValid = 1'b0;
				instr = '0;
			end
			#2;
			quietExecute();
			quietResult();
		end

		// one row per cycle with each stage checked where its row sits
		for (int i = 0; i < numVecs + 2; i++) begin
			@(negedge clk);
			instrValid = (i < numVecs);
			instr = (i < numVecs) ? vecs[i].instr : '0;
			pc = (i < numVecs) ? vecs[i].pc : '0;
			if (i >= 2)
				readData = vecs[i - 2].rdata;
			else
				readData = '0;
			#2;
			if (i >= 1 && i <= numVecs)
				checkExecute(i - 1);
			else if (i == 0)
				quietExecute();
			if (i >= 2)
				checkResult(i - 2);
			else
				quietResult();
			// empty pipe right after reset belongs to the reset test
			if (i == 1) begin
				$display("reset test had %0d mismatches", resetErrs);
				if (resetErrs == 0)
					passCount++;
				else
					failCount++;
			end
		end

		// pipeline must drain once valid drops
		drained = 1'b0;
		for (int c = 0; c < IdleTimeout && !drained; c++) begin
			@(negedge clk);
			#2;
			drained = !(memRead || memWrite || wbEnable || branchValid || overflow);
		end
		if (!drained)
			$display("timeout: pipeline still busy %0d cycles after the last vector", IdleTimeout);

		$display("tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
			failCount);
		if (failCount == 0 && drained)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
common/mipsPkg.sv
decode/regFile.sv
decode/instrDecode.sv
execute/aluExecute.sv
hdl/loadResult.sv
hdl/mipsCore.sv
verif/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - common/mipsPkg.sv
  - decode/regFile.sv
  - decode/instrDecode.sv
  - execute/aluExecute.sv
  - hdl/loadResult.sv
  - hdl/mipsCore.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/mipsCoreTb.sv
